// File: Bender.yml
package:
  name: pim_dma

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/pim_dma_pkg.sv
      - logic/pim_cmd_decode.sv
      - logic/pim_addr_gen.sv
      - logic/pim_xfer_seq.sv
      - logic/pim_dma_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/pim_dma_properties.sv
      - sim/pim_dma_tb.sv

// File: include/pim_dma_defines.svh
`ifndef PIM_DMA_DEFINES_SVH
`define PIM_DMA_DEFINES_SVH

// pim bus address map
`define PIM_BASE_ADDR   32'h4000_0000
`define PIM_MODE_ADDR   32'h4100_0000
`define PIM_ZP_ADDR     32'h4200_0000
`define PIM_STATUS_ADDR 32'h4300_0000

// bank index field inside a stream write address
`define PIM_BANK_LSB 16
`define PIM_BANK_W   4

// words per stream command
`define PIM_WORDS_PARALLEL 16
`define PIM_WORDS_RBR      2

// word count and transfer counter width
`define PIM_CNT_W 5

// all byte lanes on
`define PIM_FULL_STROBE 4'b1111

`endif

// File: logic/pim_addr_gen.sv
`timescale 1ns/1ns
`include "pim_dma_defines.svh"

module pim_addr_gen
    import pim_dma_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  pim_cmd_t    cmd_i,
    input  logic        start_i,
    input  logic        cnt_load_i,
    input  logic        cnt_step_i,
    input  logic        sram_rd_i,
    input  logic [31:0] sram_rdata_i,
    output logic        last_o,
    output logic [31:0] mem_addr_o,
    output logic [31:0] pim_addr_o,
    output logic [31:0] stream_data_o
);

    logic                  start_q;
    logic [`PIM_CNT_W-1:0] cnt_q;
    logic [`PIM_CNT_W-1:0] word_idx;
    logic [31:0]           mem_addr_q;
    logic                  rd_q;
    logic [31:0]           rdata_q;

    // cmd_i is registered on the start edge, so operand loads a cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_q    <= 1'b0;
            mem_addr_q <= '0;
            cnt_q      <= '0;
            rd_q       <= 1'b0;
        end else begin
            start_q <= start_i;
            rd_q    <= sram_rd_i;
            if (start_q) begin
                mem_addr_q <= cmd_i.operand.mem_addr;
            end else if (sram_rd_i) begin
                mem_addr_q <= mem_addr_q + 32'd4;
            end
            if (cnt_load_i) begin
                cnt_q <= cmd_i.words - 1'b1;
            end else if (cnt_step_i && !last_o) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // sram data arrives one cycle after its read
    always_ff @(posedge clk_i) begin
        if (rd_q) begin
            rdata_q <= sram_rdata_i;
        end
    end

    assign last_o     = (cnt_q == '0);
    assign mem_addr_o = mem_addr_q;

    // words already written select the bank
    assign word_idx   = cmd_i.words - 1'b1 - cnt_q;
    assign pim_addr_o = (`PIM_BASE_ADDR + cmd_i.row_col)
                      | (32'(word_idx[`PIM_BANK_W-1:0]) << `PIM_BANK_LSB);

    // bypass fresh data, else the held copy after a stall
    assign stream_data_o = rd_q ? sram_rdata_i : rdata_q;

endmodule

// File: logic/pim_cmd_decode.sv
`timescale 1ns/1ns
`include "pim_dma_defines.svh"

module pim_cmd_decode
    import pim_dma_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        dma_en_i,
    input  logic [2:0]  funct3_i,
    input  logic [11:0] imm_i,
    input  logic [31:0] rs1_i,
    input  logic [31:0] rs2_i,
    input  logic        busy_i,
    output logic        start_o,
    output pim_cmd_t    cmd_o
);

    pim_op_e               op;
    logic                  supported;
    logic [`PIM_CNT_W-1:0] words;

    pim_op_e               op_q;
    logic [`PIM_CNT_W-1:0] words_q;
    logic [31:0]           row_col_q;
    logic [11:0]           sel_q;
    pim_operand_u          operand_q;

    assign op = pim_op_e'(funct3_i);

    // opcode check and transfer length
    always_comb begin
        supported = 1'b0;
        words     = '0;
        case (op)
            OP_ERASE, OP_PROGRAM, OP_ZP: begin
                supported = 1'b1;
                words     = `PIM_CNT_W'(1);
            end
            OP_PARALLEL: begin
                supported = 1'b1;
                words     = `PIM_CNT_W'(`PIM_WORDS_PARALLEL);
            end
            OP_RBR: begin
                supported = 1'b1;
                words     = `PIM_CNT_W'(`PIM_WORDS_RBR);
            end
            // pim to sram direction has no datapath here
            OP_READ, OP_LOAD: begin
                supported = 1'b0;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // new commands only while the engine sits idle
    assign start_o = dma_en_i && !busy_i && supported;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            op_q    <= OP_NONE;
            words_q <= '0;
        end else if (start_o) begin
            op_q    <= op;
            words_q <= words;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_o) begin
            row_col_q <= rs1_i;
            sel_q     <= imm_i;
            operand_q <= rs2_i;
        end
    end

    assign cmd_o = '{op: op_q, row_col: row_col_q, sel: sel_q,
                     operand: operand_q, words: words_q};

endmodule

// File: logic/pim_dma_pkg.sv
`include "pim_dma_defines.svh"

package pim_dma_pkg;

    // funct3 encodings of the dma command
    typedef enum logic [2:0] {
        OP_NONE     = 3'd0,
        OP_ERASE    = 3'd1,
        OP_PROGRAM  = 3'd2,
        OP_READ     = 3'd3,
        OP_ZP       = 3'd4,
        OP_PARALLEL = 3'd5,
        OP_RBR      = 3'd6,
        OP_LOAD     = 3'd7
    } pim_op_e;

    // rs2 is an sram source address for streams,
    // a timing or zero-point word for single writes
    typedef union packed {
        logic [31:0] mem_addr;
        logic [31:0] data_word;
    } pim_operand_u;

    // command as held between decode and execution
    typedef struct packed {
        pim_op_e               op;
        logic [31:0]           row_col;
        logic [11:0]           sel;
        pim_operand_u          operand;
        logic [`PIM_CNT_W-1:0] words;
    } pim_cmd_t;

    // one bus port, request side
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic        read;
        logic [3:0]  size;
        logic [31:0] wdata;
    } pim_bus_t;

    // pim status word
    typedef struct packed {
        logic [30:0] rsvd;
        logic        valid;
    } pim_status_t;

endpackage

// File: logic/pim_dma_top.sv
`timescale 1ns/1ns

module pim_dma_top
    import pim_dma_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        dma_en_i,
    input  logic [2:0]  funct3_i,
    input  logic [11:0] imm_i,
    input  logic [31:0] rs1_i,
    input  logic [31:0] rs2_i,
    output logic        bus_req_o,
    input  logic        bus_gnt_i,
    output pim_bus_t    sram_bus_o,
    input  logic [31:0] sram_rdata_i,
    output pim_bus_t    pim_bus_o,
    input  logic [31:0] pim_rdata_i,
    output logic        dma_busy_o
);

    pim_cmd_t    cmd;
    logic        start;
    logic        busy;
    logic        cnt_load;
    logic        cnt_step;
    logic        sram_rd;
    logic        last;
    logic [31:0] mem_addr;
    logic [31:0] pim_addr;
    logic [31:0] stream_data;

    pim_cmd_decode u_pim_cmd_decode (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .dma_en_i (dma_en_i),
        .funct3_i (funct3_i),
        .imm_i    (imm_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .busy_i   (busy),
        .start_o  (start),
        .cmd_o    (cmd)
    );

    pim_addr_gen u_pim_addr_gen (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cmd_i         (cmd),
        .start_i       (start),
        .cnt_load_i    (cnt_load),
        .cnt_step_i    (cnt_step),
        .sram_rd_i     (sram_rd),
        .sram_rdata_i  (sram_rdata_i),
        .last_o        (last),
        .mem_addr_o    (mem_addr),
        .pim_addr_o    (pim_addr),
        .stream_data_o (stream_data)
    );

    pim_xfer_seq u_pim_xfer_seq (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cmd_i         (cmd),
        .start_i       (start),
        .bus_gnt_i     (bus_gnt_i),
        .pim_rdata_i   (pim_rdata_i),
        .last_i        (last),
        .mem_addr_i    (mem_addr),
        .pim_addr_i    (pim_addr),
        .stream_data_i (stream_data),
        .busy_o        (busy),
        .bus_req_o     (bus_req_o),
        .cnt_load_o    (cnt_load),
        .cnt_step_o    (cnt_step),
        .sram_rd_o     (sram_rd),
        .sram_bus_o    (sram_bus_o),
        .pim_bus_o     (pim_bus_o)
    );

    assign dma_busy_o = busy;

endmodule

// File: logic/pim_xfer_seq.sv
`timescale 1ns/1ns
`include "pim_dma_defines.svh"

module pim_xfer_seq
    import pim_dma_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  pim_cmd_t    cmd_i,
    input  logic        start_i,
    input  logic        bus_gnt_i,
    input  logic [31:0] pim_rdata_i,
    input  logic        last_i,
    input  logic [31:0] mem_addr_i,
    input  logic [31:0] pim_addr_i,
    input  logic [31:0] stream_data_i,
    output logic        busy_o,
    output logic        bus_req_o,
    output logic        cnt_load_o,
    output logic        cnt_step_o,
    output logic        sram_rd_o,
    output pim_bus_t    sram_bus_o,
    output pim_bus_t    pim_bus_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETUP,
        ST_MODE,
        ST_FETCH,
        ST_STREAM,
        ST_WRITE
    } state_e;

    state_e      state_q;
    state_e      state_d;
    pim_status_t status;
    logic        is_stream;
    logic [31:0] single_addr;

    assign status    = pim_status_t'(pim_rdata_i);
    assign is_stream = (cmd_i.op == OP_PARALLEL) || (cmd_i.op == OP_RBR);

    // erase and program go to the cell array, zp to its own register
    assign single_addr = (cmd_i.op == OP_ZP) ? `PIM_ZP_ADDR
                                             : `PIM_BASE_ADDR + cmd_i.row_col;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // nothing moves without grant
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    state_d = ST_SETUP;
                end
            end
            ST_SETUP: begin
                if (bus_gnt_i && status.valid) begin
                    state_d = ST_MODE;
                end
            end
            ST_MODE: begin
                if (bus_gnt_i) begin
                    state_d = is_stream ? ST_FETCH : ST_WRITE;
                end
            end
            ST_FETCH: begin
                if (bus_gnt_i) begin
                    state_d = ST_STREAM;
                end
            end
            ST_STREAM: begin
                if (bus_gnt_i && last_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_WRITE: begin
                if (bus_gnt_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign busy_o    = (state_q != ST_IDLE);
    assign bus_req_o = busy_o;

    // bus drive, all zero unless granted
    always_comb begin
        cnt_load_o = 1'b0;
        cnt_step_o = 1'b0;
        sram_rd_o  = 1'b0;
        sram_bus_o = '0;
        pim_bus_o  = '0;
        if (bus_gnt_i) begin
            case (state_q)
                ST_SETUP: begin
                    // poll status
                    pim_bus_o.addr = `PIM_STATUS_ADDR;
                    pim_bus_o.read = 1'b1;
                    pim_bus_o.size = `PIM_FULL_STROBE;
                end
                ST_MODE: begin
                    pim_bus_o.addr  = `PIM_MODE_ADDR;
                    pim_bus_o.write = 1'b1;
                    pim_bus_o.size  = `PIM_FULL_STROBE;
                    pim_bus_o.wdata = 32'(cmd_i.op);
                    cnt_load_o      = 1'b1;
                end
                ST_FETCH: begin
                    sram_rd_o = 1'b1;
                end
                ST_STREAM: begin
                    pim_bus_o.addr  = pim_addr_i;
                    pim_bus_o.write = 1'b1;
                    pim_bus_o.size  = `PIM_FULL_STROBE;
                    pim_bus_o.wdata = stream_data_i;
                    cnt_step_o      = 1'b1;
                    // no prefetch past the final word
                    sram_rd_o       = !last_i;
                end
                ST_WRITE: begin
                    pim_bus_o.addr  = single_addr;
                    pim_bus_o.write = 1'b1;
                    pim_bus_o.size  = `PIM_FULL_STROBE;
                    pim_bus_o.wdata = cmd_i.operand.data_word;
                end
                default: begin
                    pim_bus_o = '0;
                end
            endcase
        end
        if (sram_rd_o) begin
            sram_bus_o.addr = mem_addr_i;
            sram_bus_o.read = 1'b1;
            sram_bus_o.size = `PIM_FULL_STROBE;
        end
    end

endmodule

// File: sim/pim_dma_properties.sv
`timescale 1ns/1ns

module pim_dma_properties
    import pim_dma_pkg::*;
(
    input logic     clk_i,
    input logic     rst_ni,
    input logic     bus_gnt_i,
    input logic     bus_req_i,
    input logic     busy_i,
    input pim_bus_t sram_bus_i,
    input pim_bus_t pim_bus_i
);

    int fail_cnt = 0;

    // both ports quiet and zero without grant
    a_quiet_without_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !bus_gnt_i |-> (pim_bus_i == '0) && (sram_bus_i == '0))
    else begin
        fail_cnt++;
        $error("bus activity while grant is low");
    end

    // sram side only reads
    a_sram_read_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !sram_bus_i.write)
    else begin
        fail_cnt++;
        $error("write strobe on the sram port");
    end

    a_busy_implies_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        busy_i |-> bus_req_i)
    else begin
        fail_cnt++;
        $error("engine busy without bus request");
    end

endmodule

// File: sim/pim_dma_tb.sv
`timescale 1ns/1ns
`include "pim_dma_defines.svh"

module pim_dma_tb
    import pim_dma_pkg::*;
();

    typedef struct packed {
        logic [2:0]  funct3;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        rand_gnt;
        logic [7:0]  delay;
        logic [4:0]  exp_words;
        logic        poke_busy;
    } test_row_t;

    localparam int NUM_TESTS = 10;

    // exp_words of zero marks a command that must be rejected
    test_row_t tests [NUM_TESTS] = '{
        '{OP_ERASE,    32'h0000_0120, 32'h0000_00a5, 1'b0, 8'd0, 5'd1,  1'b0},
        '{OP_PROGRAM,  32'h0000_0344, 32'h1234_5678, 1'b0, 8'd2, 5'd1,  1'b0},
        '{OP_ZP,       32'h0000_0077, 32'h0000_0033, 1'b1, 8'd1, 5'd1,  1'b0},
        '{OP_PARALLEL, 32'h0000_0008, 32'h0000_1000, 1'b0, 8'd0, 5'd16, 1'b0},
        '{OP_RBR,      32'h0000_0010, 32'h0000_2040, 1'b1, 8'd5, 5'd2,  1'b0},
        '{OP_NONE,     32'h0000_0010, 32'h0000_2040, 1'b0, 8'd0, 5'd0,  1'b0},
        '{OP_READ,     32'h0000_0020, 32'h0000_2080, 1'b0, 8'd0, 5'd0,  1'b0},
        '{OP_LOAD,     32'h0000_0030, 32'h0000_20c0, 1'b0, 8'd0, 5'd0,  1'b0},
        '{OP_PARALLEL, 32'h0000_0204, 32'h0000_3000, 1'b1, 8'd3, 5'd16, 1'b1},
        '{OP_RBR,      32'h0000_0030, 32'h0000_4ff8, 1'b1, 8'd0, 5'd2,  1'b1}
    };

    logic        clk_i;
    logic        rst_ni;
    logic        dma_en_i;
    logic [2:0]  funct3_i;
    logic [11:0] imm_i;
    logic [31:0] rs1_i;
    logic [31:0] rs2_i;
    logic        bus_req_o;
    logic        bus_gnt_i;
    pim_bus_t    sram_bus_o;
    logic [31:0] sram_rdata_i;
    pim_bus_t    pim_bus_o;
    logic [31:0] pim_rdata_i;
    logic        dma_busy_o;

    integer      seed = 32'h5e4e_6c83;
    integer      rnd;
    logic        rand_gnt;
    logic [7:0]  status_delay;
    logic [7:0]  status_cnt;
    logic        status_valid;
    pim_bus_t    log_q [$];
    pim_bus_t    rd_log_q [$];
    int          early_writes;
    int          busy_seen;
    int          errors = 0;

    pim_dma_top u_pim_dma_top (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .dma_en_i     (dma_en_i),
        .funct3_i     (funct3_i),
        .imm_i        (imm_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .bus_req_o    (bus_req_o),
        .bus_gnt_i    (bus_gnt_i),
        .sram_bus_o   (sram_bus_o),
        .sram_rdata_i (sram_rdata_i),
        .pim_bus_o    (pim_bus_o),
        .pim_rdata_i  (pim_rdata_i),
        .dma_busy_o   (dma_busy_o)
    );

    bind pim_dma_top pim_dma_properties u_pim_dma_properties (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .bus_gnt_i  (bus_gnt_i),
        .bus_req_i  (bus_req_o),
        .busy_i     (dma_busy_o),
        .sram_bus_i (sram_bus_o),
        .pim_bus_i  (pim_bus_o)
    );

    always #2 clk_i = ~clk_i;

    // sram contents as a function of the full byte address
    function automatic logic [31:0] sram_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[7:0], addr[31:8]};
    endfunction

    // sram answers one cycle after the read strobe
    always @(posedge clk_i) begin
        if (sram_bus_o.read) begin
            sram_rdata_i <= sram_word(sram_bus_o.addr);
        end
    end

    always @(posedge clk_i) begin
        rnd = $random(seed);
        bus_gnt_i <= rand_gnt ? rnd[0] : 1'b1;
    end

    // status turns valid status_delay cycles into a command
    always @(posedge clk_i) begin
        if (!dma_busy_o) begin
            status_cnt <= '0;
        end else if (status_cnt != 8'hff) begin
            status_cnt <= status_cnt + 1'b1;
        end
    end

    assign status_valid = dma_busy_o && (status_cnt >= status_delay);

    // status word only answers a poll of its own address
    assign pim_rdata_i = (pim_bus_o.read && pim_bus_o.addr == `PIM_STATUS_ADDR)
                       ? {31'd0, status_valid} : 32'd0;

    // log every pim write and every sram read
    always @(posedge clk_i) begin
        if (rst_ni && pim_bus_o.write) begin
            log_q.push_back(pim_bus_o);
            if (!status_valid) begin
                early_writes++;
            end
        end
        if (rst_ni && sram_bus_o.read) begin
            rd_log_q.push_back(sram_bus_o);
        end
        if (dma_busy_o) begin
            busy_seen++;
        end
    end

    // write idx 0 is the mode write, the rest carry data
    function automatic pim_bus_t expected_write(input test_row_t row, input int idx);
        pim_bus_t    exp;
        logic [31:0] base;
        exp       = '0;
        exp.write = 1'b1;
        exp.size  = `PIM_FULL_STROBE;
        base      = `PIM_BASE_ADDR + row.rs1;
        if (idx == 0) begin
            exp.addr  = `PIM_MODE_ADDR;
            exp.wdata = {29'd0, row.funct3};
        end else if (row.funct3 == OP_ZP) begin
            exp.addr  = `PIM_ZP_ADDR;
            exp.wdata = row.rs2;
        end else if (row.funct3 == OP_ERASE || row.funct3 == OP_PROGRAM) begin
            exp.addr  = base;
            exp.wdata = row.rs2;
        end else begin
            exp.addr  = base | (32'(idx - 1) << `PIM_BANK_LSB);
            exp.wdata = sram_word(row.rs2 + 32'(4 * (idx - 1)));
        end
        return exp;
    endfunction

    // stream word idx is read from the source address plus 4 per word
    function automatic pim_bus_t expected_read(input test_row_t row, input int idx);
        pim_bus_t exp;
        exp      = '0;
        exp.addr = row.rs2 + 32'(4 * idx);
        exp.read = 1'b1;
        exp.size = `PIM_FULL_STROBE;
        return exp;
    endfunction

    task automatic check_bus(input pim_bus_t got, input pim_bus_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is addr %h wr %b rd %b size %h data %h,",
                     $time, what, got.addr, got.write, got.read, got.size, got.wdata);
            $display("    expected addr %h wr %b rd %b size %h data %h",
                     exp.addr, exp.write, exp.read, exp.size, exp.wdata);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wait_busy(input logic level, input int limit, output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < limit; n++) begin
            @(posedge clk_i);
            if (dma_busy_o == level) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    initial begin
        int        i;
        int        k;
        int        n_exp;
        int        n_rd;
        int        test_err;
        int        run;
        int        passed;
        logic      ok;
        logic      timed_out;
        test_row_t row;
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        dma_en_i     = 1'b0;
        funct3_i     = '0;
        imm_i        = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        bus_gnt_i    = 1'b0;
        sram_rdata_i = '0;
        rand_gnt     = 1'b0;
        status_delay = '0;
        status_cnt   = '0;
        run          = 0;
        passed       = 0;
        timed_out    = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);
        check_count(int'(dma_busy_o) + int'(bus_req_o), 0, "busy and request after reset");
        check_bus(pim_bus_o, '0, "pim port after reset");
        check_bus(sram_bus_o, '0, "sram port after reset");

        for (i = 0; i < NUM_TESTS; i++) begin
            row      = tests[i];
            test_err = errors;
            run++;
            log_q.delete();
            rd_log_q.delete();
            early_writes = 0;
            busy_seen    = 0;
            rand_gnt     <= row.rand_gnt;
            status_delay <= row.delay;
            dma_en_i     <= 1'b1;
            funct3_i     <= row.funct3;
            rs1_i        <= row.rs1;
            rs2_i        <= row.rs2;
            imm_i        <= 12'(i);
            @(posedge clk_i);
            dma_en_i <= 1'b0;
            if (row.exp_words == 0) begin
                repeat (8) @(posedge clk_i);
                check_count(busy_seen, 0, $sformatf("test %0d busy cycles", i));
            end else begin
                wait_busy(1'b1, 4, ok);
                if (ok && row.poke_busy) begin
                    // second command while busy must be dropped
                    @(posedge clk_i);
                    dma_en_i <= 1'b1;
                    funct3_i <= OP_ERASE;
                    rs1_i    <= 32'h0000_0bad;
                    @(posedge clk_i);
                    dma_en_i <= 1'b0;
                end
                if (ok) begin
                    wait_busy(1'b0, 400, ok);
                end
                if (!ok) begin
                    $display("timeout in test %0d, busy never settled", i);
                    timed_out = 1'b1;
                    break;
                end
            end
            n_exp = (row.exp_words == 0) ? 0 : row.exp_words + 1;
            check_count(log_q.size(), n_exp, $sformatf("test %0d pim writes", i));
            check_count(early_writes, 0, $sformatf("test %0d writes before status", i));
            for (k = 0; k < log_q.size() && k < n_exp; k++) begin
                check_bus(log_q[k], expected_write(row, k),
                          $sformatf("test %0d write %0d", i, k));
            end
            // streams read each source word once, single writes read nothing
            n_rd = (row.funct3 == OP_PARALLEL || row.funct3 == OP_RBR)
                 ? int'(row.exp_words) : 0;
            check_count(rd_log_q.size(), n_rd, $sformatf("test %0d sram reads", i));
            for (k = 0; k < rd_log_q.size() && k < n_rd; k++) begin
                check_bus(rd_log_q[k], expected_read(row, k),
                          $sformatf("test %0d read %0d", i, k));
            end
            if (errors == test_err) begin
                passed++;
                $display("test %0d funct3 %0d: pass", i, row.funct3);
            end else begin
                $display("test %0d funct3 %0d: fail, %0d mismatches", i, row.funct3,
                         errors - test_err);
            end
        end

        errors += u_pim_dma_top.u_pim_dma_properties.fail_cnt;
        $display("%0d tests run, %0d passed, %0d errors incl. %0d assertion failures",
                 run, passed, errors, u_pim_dma_top.u_pim_dma_properties.fail_cnt);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
logic/pim_dma_pkg.sv
logic/pim_cmd_decode.sv
logic/pim_addr_gen.sv
logic/pim_xfer_seq.sv
logic/pim_dma_top.sv
sim/pim_dma_properties.sv
sim/pim_dma_tb.sv
